// ==== axi_rd_subsystem.f ====
hw/axi_rd_pkg.sv
hw/axi_rd_if.sv
hw/axi_ar_decoder.sv
hw/axi_rd_mem_slave.sv
hw/axi_slave_mux_r.sv
hw/axi_rd_subsystem.sv
tests/axi_rd_properties.sv
tests/tb_axi_rd_subsystem.sv

// ==== hw/axi_ar_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_ar_decoder import axi_rd_pkg::*; (
    axi_ar_if.slave  mst,
    axi_ar_if.master s0,
    axi_ar_if.master s1,
    axi_ar_if.master s3
);

    slot_e      sel;
    logic [1:0] region;

    assign region = mst.araddr[REGION_LSB +: 2];

    // Region 2 has no slave; slot 3 answers it with DECERR.
    always_comb begin
        case (region)
            2'd0:    sel = SLOT_S0;
            2'd1:    sel = SLOT_S1;
            default: sel = SLOT_S3;
        endcase
    end

    // Payload is broadcast and only valid is steered.
    assign s0.arid   = mst.arid;
    assign s0.araddr = mst.araddr;
    assign s0.arlen  = mst.arlen;
    assign s1.arid   = mst.arid;
    assign s1.araddr = mst.araddr;
    assign s1.arlen  = mst.arlen;
    assign s3.arid   = mst.arid;
    assign s3.araddr = mst.araddr;
    assign s3.arlen  = mst.arlen;

    always_comb begin
        s0.arvalid = 1'b0;
        s1.arvalid = 1'b0;
        s3.arvalid = 1'b0;
        case (sel)
            SLOT_S1: begin
                s1.arvalid = mst.arvalid;
                mst.arready = s1.arready;
            end
            SLOT_S3: begin
                s3.arvalid = mst.arvalid;
                mst.arready = s3.arready;
            end
            default: begin
                s0.arvalid = mst.arvalid;
                mst.arready = s0.arready;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/axi_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Read address channel.
interface axi_ar_if #(
    parameter int unsigned ID_WIDTH   = 8,
    parameter int unsigned ADDR_WIDTH = 16
);
    logic                  arvalid;
    logic                  arready;
    logic [ID_WIDTH-1:0]   arid;
    logic [ADDR_WIDTH-1:0] araddr;
    logic [7:0]            arlen;   // Beats minus one.

    modport master (
        output arvalid, arid, araddr, arlen,
        input  arready
    );

    modport slave (
        input  arvalid, arid, araddr, arlen,
        output arready
    );
endinterface

// Read data channel.
interface axi_r_if import axi_rd_pkg::*; #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned ID_WIDTH   = 8
);
    logic                  rvalid;
    logic                  rready;
    logic [ID_WIDTH-1:0]   rid;
    logic [DATA_WIDTH-1:0] rdata;
    axi_resp_e             rresp;
    logic                  rlast;

    modport slave (
        output rvalid, rid, rdata, rresp, rlast,
        input  rready
    );

    modport master (
        input  rvalid, rid, rdata, rresp, rlast,
        output rready
    );
endinterface

`default_nettype wire

// ==== hw/axi_rd_mem_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rd_mem_slave import axi_rd_pkg::*; #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned ID_WIDTH   = 8,
    parameter int unsigned ADDR_WIDTH = 16,
    parameter int unsigned REGION     = 0
) (
    input logic      clk_i,
    input logic      rst_ni,
    axi_ar_if.slave  ar,
    axi_r_if.slave   r
);

    localparam int unsigned BYTE_BITS = $clog2(DATA_WIDTH / 8);
    localparam int unsigned IDX_W     = $clog2(ROM_WORDS);
    localparam int unsigned IMG_WORDS = 3 * ROM_WORDS;

    // Slot 3 owns the third block of the image.
    localparam int unsigned SLOT_BASE = ((REGION == 3) ? 2 : REGION) * ROM_WORDS;

    typedef enum logic {
        ST_IDLE,
        ST_BURST
    } state_e;

    state_e                state_q;
    state_e                state_d;
    logic [DATA_WIDTH-1:0] image [IMG_WORDS];
    logic [ADDR_WIDTH-1:0] ar_addr;
    logic                  ar_hs;
    logic                  r_hs;
    logic                  last_beat;

    logic [ID_WIDTH-1:0]   id_q;
    logic [IDX_W-1:0]      idx_q;
    logic [7:0]            rem_q;     // Beats left after this one.
    logic                  decerr_q;

    initial begin
        $readmemh("hw/rd_rom.hex", image);
    end

    assign ar_addr   = ar.araddr;
    assign ar_hs     = ar.arvalid && (state_q == ST_IDLE);
    assign r_hs      = (state_q == ST_BURST) && r.rready;
    assign last_beat = (rem_q == 8'd0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (ar_hs) begin
                    state_d = ST_BURST;
                end
            end
            ST_BURST: begin
                if (r_hs && last_beat) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            id_q     <= ar.arid;
            idx_q    <= ar_addr[BYTE_BITS +: IDX_W];
            rem_q    <= ar.arlen;
            decerr_q <= (ar_addr[REGION_LSB +: 2] != 2'(REGION));
        end else if (r_hs) begin
            idx_q <= idx_q + 1'b1;   // Wraps inside the slot.
            rem_q <= rem_q - 8'd1;
        end
    end

    assign ar.arready = (state_q == ST_IDLE);

    assign r.rvalid = (state_q == ST_BURST);
    assign r.rid    = id_q;
    assign r.rlast  = (state_q == ST_BURST) && last_beat;
    assign r.rdata  = decerr_q ? '0 : image[SLOT_BASE + idx_q];
    assign r.rresp  = decerr_q ? RESP_DECERR : RESP_OKAY;

endmodule

`default_nettype wire

// ==== hw/axi_rd_pkg.sv ====
`default_nettype none

package axi_rd_pkg;

    // AXI read response codes.
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // Slave slots numbered as on the interconnect.
    typedef enum logic [1:0] {
        SLOT_S0 = 2'd0,
        SLOT_S1 = 2'd1,
        SLOT_S3 = 2'd3
    } slot_e;

    // Region field sits at address bits [7:6] with 64 bytes each.
    localparam int unsigned REGION_LSB = 6;

    // Words held by each slave.
    localparam int unsigned ROM_WORDS = 16;

endpackage

`default_nettype wire

// ==== hw/axi_rd_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rd_subsystem #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned ID_WIDTH   = 8,
    parameter int unsigned ADDR_WIDTH = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  ar_valid,
    input  logic [ID_WIDTH-1:0]   ar_id,
    input  logic [ADDR_WIDTH-1:0] ar_addr,
    input  logic [7:0]            ar_len,
    output logic                  ar_ready,
    output logic                  r_valid,
    output logic [ID_WIDTH-1:0]   r_id,
    output logic [DATA_WIDTH-1:0] r_data,
    output logic [1:0]            r_resp,
    output logic                  r_last,
    input  logic                  r_ready
);

    axi_ar_if #(.ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) ar_mst ();
    axi_ar_if #(.ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) ar_s0 ();
    axi_ar_if #(.ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) ar_s1 ();
    axi_ar_if #(.ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) ar_s3 ();

    axi_r_if #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) r_s0 ();
    axi_r_if #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) r_s1 ();
    axi_r_if #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) r_s3 ();

    assign ar_mst.arvalid = ar_valid;
    assign ar_mst.arid    = ar_id;
    assign ar_mst.araddr  = ar_addr;
    assign ar_mst.arlen   = ar_len;
    assign ar_ready       = ar_mst.arready;

    axi_ar_decoder i_ar_decoder (
        .mst (ar_mst),
        .s0  (ar_s0),
        .s1  (ar_s1),
        .s3  (ar_s3)
    );

    axi_rd_mem_slave #(
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .REGION     (0)
    ) i_slave_0 (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .ar     (ar_s0),
        .r      (r_s0)
    );

    axi_rd_mem_slave #(
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .REGION     (1)
    ) i_slave_1 (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .ar     (ar_s1),
        .r      (r_s1)
    );

    // Also takes region 2 and answers it with DECERR.
    axi_rd_mem_slave #(
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .REGION     (3)
    ) i_slave_3 (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .ar     (ar_s3),
        .r      (r_s3)
    );

    axi_slave_mux_r #(
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) i_mux_r (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .s0      (r_s0),
        .s1      (r_s1),
        .s3      (r_s3),
        .r_valid (r_valid),
        .r_id    (r_id),
        .r_data  (r_data),
        .r_resp  (r_resp),
        .r_last  (r_last),
        .r_ready (r_ready)
    );

endmodule

`default_nettype wire

// ==== hw/axi_slave_mux_r.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_slave_mux_r import axi_rd_pkg::*; #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned ID_WIDTH   = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    axi_r_if.master               s0,
    axi_r_if.master               s1,
    axi_r_if.master               s3,
    output logic                  r_valid,
    output logic [ID_WIDTH-1:0]   r_id,
    output logic [DATA_WIDTH-1:0] r_data,
    output logic [1:0]            r_resp,
    output logic                  r_last,
    input  logic                  r_ready
);

    slot_e grant_q;
    slot_e grant_d;
    logic  locked_q;    // Burst in progress.
    logic  locked_d;
    logic  beat;
    logic  done;
    logic  v0;
    logic  v1;
    logic  v3;
    logic  cur_pending;

    // Granted slave straight through to the master side.
    always_comb begin
        s0.rready = 1'b0;
        s1.rready = 1'b0;
        s3.rready = 1'b0;
        case (grant_q)
            SLOT_S1: begin
                r_valid   = s1.rvalid;
                r_id      = s1.rid;
                r_data    = s1.rdata;
                r_resp    = s1.rresp;
                r_last    = s1.rlast;
                s1.rready = r_ready;
            end
            SLOT_S3: begin
                r_valid   = s3.rvalid;
                r_id      = s3.rid;
                r_data    = s3.rdata;
                r_resp    = s3.rresp;
                r_last    = s3.rlast;
                s3.rready = r_ready;
            end
            default: begin
                r_valid   = s0.rvalid;
                r_id      = s0.rid;
                r_data    = s0.rdata;
                r_resp    = s0.rresp;
                r_last    = s0.rlast;
                s0.rready = r_ready;
            end
        endcase
    end

    assign beat = r_valid && r_ready;
    assign done = beat && r_last;

    // A slave whose last beat goes out now has nothing left.
    assign v0 = s0.rvalid && !(done && (grant_q == SLOT_S0));
    assign v1 = s1.rvalid && !(done && (grant_q == SLOT_S1));
    assign v3 = s3.rvalid && !(done && (grant_q == SLOT_S3));

    always_comb begin
        case (grant_q)
            SLOT_S1: cur_pending = v1;
            SLOT_S3: cur_pending = v3;
            default: cur_pending = v0;
        endcase
    end

    always_comb begin
        grant_d = grant_q;
        if ((!locked_q || done) && !cur_pending) begin
            if (v0)      grant_d = SLOT_S0;
            else if (v1) grant_d = SLOT_S1;
            else if (v3) grant_d = SLOT_S3;
        end
    end

    always_comb begin
        locked_d = locked_q;
        if (done) begin
            locked_d = 1'b0;
        end else if (beat) begin
            locked_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            grant_q  <= SLOT_S0;
            locked_q <= 1'b0;
        end else begin
            grant_q  <= grant_d;
            locked_q <= locked_d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rd_rom.hex ====
// One 32-bit word per line: slot 0 words 0-15, then slot 1, then slot 3.
// Pattern A0, word number, then the word number subtracted from FFFF.
A000FFFF
A001FFFE
A002FFFD
A003FFFC
A004FFFB
A005FFFA
A006FFF9
A007FFF8
A008FFF7
A009FFF6
A00AFFF5
A00BFFF4
A00CFFF3
A00DFFF2
A00EFFF1
A00FFFF0
A010FFEF
A011FFEE
A012FFED
A013FFEC
A014FFEB
A015FFEA
A016FFE9
A017FFE8
A018FFE7
A019FFE6
A01AFFE5
A01BFFE4
A01CFFE3
A01DFFE2
A01EFFE1
A01FFFE0
A020FFDF
A021FFDE
A022FFDD
A023FFDC
A024FFDB
A025FFDA
A026FFD9
A027FFD8
A028FFD7
A029FFD6
A02AFFD5
A02BFFD4
A02CFFD3
A02DFFD2
A02EFFD1
A02FFFD0

// ==== run.sh ====
#!/bin/sh
# Build the simulation with Verilator and run it; the exit status is the result.
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module tb_axi_rd_subsystem \
    -f axi_rd_subsystem.f -Mdir obj_dir -o sim_tb
./obj_dir/sim_tb

// ==== tests/axi_rd_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rd_properties #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned ID_WIDTH   = 8
) (
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  r_valid,
    input logic                  r_ready,
    input logic [ID_WIDTH-1:0]   r_id,
    input logic [DATA_WIDTH-1:0] r_data,
    input logic [1:0]            r_resp,
    input logic                  r_last
);

    // A stalled beat keeps its payload.
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (r_valid && !r_ready) |=> (r_valid && $stable(r_id) && $stable(r_data)
                                   && $stable(r_resp) && $stable(r_last)))
        else $error("R payload changed while stalled");

    assert property (@(posedge clk_i) !rst_ni |=> !r_valid)
        else $error("r_valid high after a reset cycle");

    // Last flag only shows up on a valid beat.
    assert property (@(posedge clk_i) disable iff (!rst_ni) r_last |-> r_valid)
        else $error("r_last high without r_valid");

endmodule

bind axi_rd_subsystem axi_rd_properties #(
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH)
) i_properties (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .r_valid (r_valid),
    .r_ready (r_ready),
    .r_id    (r_id),
    .r_data  (r_data),
    .r_resp  (r_resp),
    .r_last  (r_last)
);

`default_nettype wire

// ==== tests/tb_axi_rd_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rd_subsystem import axi_rd_pkg::*; ();

    localparam int unsigned DATA_WIDTH     = 32;
    localparam int unsigned ID_WIDTH       = 8;
    localparam int unsigned ADDR_WIDTH     = 16;
    localparam int unsigned CLK_HALF       = 50;
    localparam int unsigned DRIVE_DLY      = 10;
    // About 120 bursts of at most 16 beats. Back-pressure on half of them doubles their time.
    localparam int unsigned TIMEOUT_CYCLES = 4000;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  ar_valid;
    logic [ID_WIDTH-1:0]   ar_id;
    logic [ADDR_WIDTH-1:0] ar_addr;
    logic [7:0]            ar_len;
    logic                  ar_ready;
    logic                  r_valid;
    logic [ID_WIDTH-1:0]   r_id;
    logic [DATA_WIDTH-1:0] r_data;
    logic [1:0]            r_resp;
    logic                  r_last;
    logic                  r_ready;
    logic                  bp_en;   // Random r_ready when set.

    logic [DATA_WIDTH-1:0] rom [3*ROM_WORDS];
    logic [ID_WIDTH-1:0]   req_id_q [$];
    logic [ADDR_WIDTH-1:0] req_addr_q [$];
    logic [7:0]            req_len_q [$];

    axi_rd_subsystem #(
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_dut (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .ar_valid (ar_valid),
        .ar_id    (ar_id),
        .ar_addr  (ar_addr),
        .ar_len   (ar_len),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_id     (r_id),
        .r_data   (r_data),
        .r_resp   (r_resp),
        .r_last   (r_last),
        .r_ready  (r_ready)
    );

    initial begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    initial begin
        $readmemh("hw/rd_rom.hex", rom);
    end

    // Expected {resp, data} for one beat of a burst.
    function automatic logic [33:0] expected_beat(input logic [ADDR_WIDTH-1:0] addr,
                                                  input int unsigned beat,
                                                  input logic [1:0] region);
        logic [3:0]  word;
        int unsigned base;
        word = addr[5:2] + 4'(beat);   // Wraps inside 16 words.
        case (region)
            2'd0: base = 0;
            2'd1: base = ROM_WORDS;
            2'd3: base = 2 * ROM_WORDS;
            default: return {RESP_DECERR, 32'h0};
        endcase
        return {RESP_OKAY, rom[base + 32'(word)]};
    endfunction

    function automatic logic id_open(input logic [ID_WIDTH-1:0] id);
        foreach (req_id_q[i]) begin
            if (req_id_q[i] == id) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, expected);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Called just after a rising edge; returns at the same point.
    task automatic send_read(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                             input logic [7:0] len);
        ar_valid = 1'b1;
        ar_id    = id;
        ar_addr  = addr;
        ar_len   = len;
        @(negedge clk_i);
        while (!ar_ready) begin
            @(negedge clk_i);
        end
        req_id_q.push_back(id);
        req_addr_q.push_back(addr);
        req_len_q.push_back(len);
        @(posedge clk_i);
        #DRIVE_DLY;
        ar_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (req_id_q.size() != 0) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    task automatic random_read();
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        do begin
            id = 8'($urandom);
        end while (id_open(id));   // One open burst per ID.
        addr = {8'($urandom), 2'($urandom_range(0, 3)), 4'($urandom), 2'b00};
        send_read(id, addr, 8'($urandom_range(0, 15)));
    endtask

    // One burst per slot plus one to region 2.
    task automatic issue_mixed(input logic [ID_WIDTH-1:0] base_id);
        send_read(base_id, 16'h0010, 8'd7);
        send_read(base_id + 8'd1, 16'h0048, 8'd5);
        send_read(base_id + 8'd2, 16'h00C4, 8'd9);
        send_read(base_id + 8'd3, 16'h0080, 8'd3);
        wait_idle();
    endtask

    initial begin
        forever begin
            @(posedge clk_i);
            #DRIVE_DLY;
            r_ready = bp_en ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    end

    initial begin : monitor
        int                  idx;
        int unsigned         beat;
        logic [33:0]         want;
        logic [7:0]          len;
        logic [ID_WIDTH-1:0] burst_id;
        beat     = 0;
        burst_id = '0;
        forever begin
            @(negedge clk_i);
            if (rst_ni && r_valid && r_ready) begin
                if (beat != 0) begin
                    check("r_id", 32'(r_id), 32'(burst_id));   // No interleaving.
                end
                idx = -1;
                foreach (req_id_q[i]) begin
                    if (idx < 0 && req_id_q[i] == r_id) begin
                        idx = i;
                    end
                end
                if (idx < 0) begin
                    $display("A beat with ID %0h arrived with no open burst for it.", r_id);
                    $display("Something failed");
                    $fatal(1, "unexpected beat");
                end else begin
                    len  = req_len_q[idx];
                    want = expected_beat(req_addr_q[idx], beat,
                                         req_addr_q[idx][REGION_LSB +: 2]);
                    check("r_data", r_data, want[31:0]);
                    check("r_resp", 32'(r_resp), 32'(want[33:32]));
                    check("r_last", 32'(r_last), 32'(beat == 32'(len)));
                    burst_id = r_id;
                    if (beat == 32'(len)) begin
                        req_id_q.delete(idx);
                        req_addr_q.delete(idx);
                        req_len_q.delete(idx);
                        beat = 0;
                    end else begin
                        beat++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
        $display("Something failed");
        $fatal(1, "timeout");
    end

    initial begin : stimulus
        void'($urandom(32'h2428));
        rst_ni   = 1'b0;
        ar_valid = 1'b0;
        ar_id    = '0;
        ar_addr  = '0;
        ar_len   = '0;
        r_ready  = 1'b0;
        bp_en    = 1'b0;
        repeat (8) @(posedge clk_i);
        #DRIVE_DLY;
        rst_ni = 1'b1;

        // Every region and length with one burst at a time. Region 2 gives DECERR.
        for (int r = 0; r < 4; r++) begin
            for (int len = 0; len < 16; len++) begin
                send_read(8'(16 * r + len), {8'h00, 2'(r), 4'h0, 2'b00}, 8'(len));
                wait_idle();
            end
        end

        issue_mixed(8'h40);
        bp_en = 1'b1;
        issue_mixed(8'h50);

        // Start words near the top of each slot.
        for (int r = 0; r < 4; r++) begin
            send_read(8'(8'h60 + r), {8'h12, 2'(r), 4'hC, 2'b00}, 8'd7);
            send_read(8'(8'h70 + r), {8'hA5, 2'(r), 4'hF, 2'b00}, 8'd15);
        end
        wait_idle();

        repeat (40) random_read();
        wait_idle();

        // No beat may follow once every burst is done.
        repeat (4) @(negedge clk_i);
        check("r_valid", 32'(r_valid), 32'd0);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
